// File: rtl/poly_num_pkg.sv
package poly_num_pkg;

	// every arithmetic value is signed and wraps at this width
	localparam int data_width = 12;

	// entered values are sign-extended to data_width
	localparam int entry_width = 5;

	localparam int num_points = 4;
	localparam int num_coefs = 4;
	localparam int point_idx_width = $clog2(num_points);

	// gradient sums are divided by 64 before the update
	localparam int grad_shift = 6;

	// plot coordinate widths seen by the plotter
	localparam int x_coord_width = 9;
	localparam int y_coord_width = 8;

	typedef logic signed [data_width-1:0] value_t;

	// one entry per sample point
	typedef value_t [num_points-1:0] point_vec_t;

	// index k holds the coefficient of x^k
	typedef value_t [num_coefs-1:0] coef_vec_t;

endpackage

// File: rtl/poly_ctrl_pkg.sv
package poly_ctrl_pkg;

	// gradient-descent iterations per run
	localparam int num_iterations = 100;
	localparam int iter_width = $clog2(num_iterations + 1);

	typedef enum logic [3:0] {
		st_idle,
		// point entry, x then y
		st_get_x,
		st_wait_y,
		st_get_y,
		// draw request for the completed point
		st_show_point,
		// training loop
		st_step,
		st_step_wait,
		st_plot_wait,
		st_done
	} ctrl_state_t;

endpackage

// File: rtl/hypothesis_eval.sv
module hypothesis_eval (
	input  logic                    clock,
	input  logic                    reset,
	input  poly_num_pkg::value_t    x,
	input  poly_num_pkg::coef_vec_t coefs,
	input  logic                    valid_in,
	output poly_num_pkg::value_t    h,
	output logic                    valid_out
);

	poly_num_pkg::value_t x_sq;
	poly_num_pkg::value_t x_cb;
	poly_num_pkg::value_t term1;
	poly_num_pkg::value_t term2;
	poly_num_pkg::value_t term3;
	poly_num_pkg::value_t sum1;
	poly_num_pkg::value_t sum2;
	poly_num_pkg::value_t sum3;
	logic ovf1;
	logic ovf2;
	logic ovf3;

	// operands agree in sign but the result does not
	function automatic logic add_ovf(poly_num_pkg::value_t a, poly_num_pkg::value_t b,
		poly_num_pkg::value_t s);
		return (a[poly_num_pkg::data_width-1] == b[poly_num_pkg::data_width-1]) &&
			(s[poly_num_pkg::data_width-1] != a[poly_num_pkg::data_width-1]);
	endfunction

	// products keep only the low data_width bits
	assign x_sq = x * x;
	assign x_cb = x * x_sq;
	assign term1 = coefs[1] * x;
	assign term2 = coefs[2] * x_sq;
	assign term3 = coefs[3] * x_cb;

	assign sum1 = coefs[0] + term1;
	assign sum2 = sum1 + term2;
	assign sum3 = sum2 + term3;

	assign ovf1 = add_ovf(coefs[0], term1, sum1);
	assign ovf2 = add_ovf(sum1, term2, sum2);
	assign ovf3 = add_ovf(sum2, term3, sum3);

	always_ff @(posedge clock) begin
		if (reset || ovf1 || ovf2 || ovf3)
			h <= '0;
		else
			h <= sum3;
		valid_out <= reset ? 1'b0 : valid_in;
	end

endmodule

// File: rtl/gradient_step.sv
module gradient_step (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     clear,
	input  logic                     step,
	input  poly_num_pkg::point_vec_t xs,
	input  poly_num_pkg::point_vec_t ys,
	output poly_num_pkg::coef_vec_t  params,
	output logic                     step_done
);

	// stage 1 results, one per point
	poly_num_pkg::point_vec_t h;
	logic [poly_num_pkg::num_points-1:0] h_valid;

	// stage 2 working values
	poly_num_pkg::value_t err;
	poly_num_pkg::value_t x_sq;
	poly_num_pkg::value_t x_cb;
	poly_num_pkg::coef_vec_t sums;
	poly_num_pkg::coef_vec_t grad;

	// stage 2 registers
	poly_num_pkg::coef_vec_t grad_q;
	logic grad_valid;

	genvar i;
	generate
		for (i = 0; i < poly_num_pkg::num_points; i++) begin : g_hyp
			hypothesis_eval u_hyp (
				.clock     (clock),
				.reset     (reset),
				.x         (xs[i]),
				.coefs     (params),
				.valid_in  (step),
				.h         (h[i]),
				.valid_out (h_valid[i])
			);
		end
	endgenerate

	// errors and power-weighted sums, all wrapping
	always_comb begin
		sums = '0;
		err = '0;
		x_sq = '0;
		x_cb = '0;
		for (int p = 0; p < poly_num_pkg::num_points; p++) begin
			err = h[p] - ys[p];
			x_sq = xs[p] * xs[p];
			x_cb = xs[p] * x_sq;
			sums[0] = sums[0] + err;
			sums[1] = sums[1] + xs[p] * err;
			sums[2] = sums[2] + x_sq * err;
			sums[3] = sums[3] + x_cb * err;
		end
		for (int k = 0; k < poly_num_pkg::num_coefs; k++)
			grad[k] = $signed(sums[k]) >>> poly_num_pkg::grad_shift;
	end

	always_ff @(posedge clock) begin
		grad_q <= grad;
	end

	// step pulse follows the data through each stage
	always_ff @(posedge clock) begin
		if (reset) begin
			grad_valid <= 1'b0;
			step_done <= 1'b0;
		end else begin
			grad_valid <= &h_valid;
			step_done <= grad_valid;
		end
	end

	// stage 3, coefficient update
	always_ff @(posedge clock) begin
		if (reset || clear) begin
			params <= '0;
		end else if (grad_valid) begin
			for (int k = 0; k < poly_num_pkg::num_coefs; k++)
				params[k] <= params[k] - grad_q[k];
		end
	end

endmodule

// File: rtl/poly_control.sv
module poly_control (
	input  logic                                      clock,
	input  logic                                      reset,
	input  logic                                      enter,
	input  logic signed [poly_num_pkg::entry_width-1:0] data_in,
	input  logic                                      plot_done,
	input  logic                                      step_done,
	output poly_num_pkg::point_vec_t                  xs,
	output poly_num_pkg::point_vec_t                  ys,
	output logic [poly_num_pkg::x_coord_width-1:0]    x_val,
	output logic [poly_num_pkg::y_coord_width-1:0]    y_val,
	output logic                                      draw,
	output logic                                      clear,
	output logic                                      step,
	output logic                                      finished
);

	poly_ctrl_pkg::ctrl_state_t state;
	poly_ctrl_pkg::ctrl_state_t next_state;
	logic [poly_num_pkg::point_idx_width-1:0] point_idx;
	logic [poly_ctrl_pkg::iter_width-1:0] iter_count;
	poly_num_pkg::value_t data_ext;
	logic last_point;
	logic last_iter;
	logic start_x;

	assign data_ext = poly_num_pkg::value_t'(data_in);
	assign last_point = (int'(point_idx) == poly_num_pkg::num_points - 1);
	assign last_iter = (int'(iter_count) == poly_ctrl_pkg::num_iterations);

	// a fresh press that opens the next x value
	assign start_x = (next_state == poly_ctrl_pkg::st_get_x) &&
		(state != poly_ctrl_pkg::st_get_x);

	always_comb begin
		next_state = state;
		case (state)
			poly_ctrl_pkg::st_idle,
			poly_ctrl_pkg::st_done: begin
				if (enter)
					next_state = poly_ctrl_pkg::st_get_x;
			end
			poly_ctrl_pkg::st_get_x: begin
				if (!enter)
					next_state = poly_ctrl_pkg::st_wait_y;
			end
			poly_ctrl_pkg::st_wait_y: begin
				if (enter)
					next_state = poly_ctrl_pkg::st_get_y;
			end
			poly_ctrl_pkg::st_get_y: begin
				if (!enter)
					next_state = poly_ctrl_pkg::st_show_point;
			end
			poly_ctrl_pkg::st_show_point: begin
				// the fourth point goes straight into training
				if (last_point)
					next_state = poly_ctrl_pkg::st_step;
				else if (enter)
					next_state = poly_ctrl_pkg::st_get_x;
			end
			poly_ctrl_pkg::st_step: begin
				next_state = poly_ctrl_pkg::st_step_wait;
			end
			poly_ctrl_pkg::st_step_wait: begin
				if (step_done)
					next_state = poly_ctrl_pkg::st_plot_wait;
			end
			poly_ctrl_pkg::st_plot_wait: begin
				// a slow plotter just holds us here
				if (plot_done)
					next_state = last_iter ? poly_ctrl_pkg::st_done : poly_ctrl_pkg::st_step;
			end
			default: begin
				next_state = poly_ctrl_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= poly_ctrl_pkg::st_idle;
			point_idx <= '0;
			iter_count <= '0;
			draw <= 1'b0;
		end else begin
			state <= next_state;

			// new run restarts at point 0, otherwise advance
			if (start_x && state != poly_ctrl_pkg::st_show_point)
				point_idx <= '0;
			else if (start_x)
				point_idx <= point_idx + 1'b1;

			if (clear)
				iter_count <= '0;
			else if (state == poly_ctrl_pkg::st_step_wait && step_done)
				iter_count <= iter_count + 1'b1;

			if (state == poly_ctrl_pkg::st_get_y && !enter)
				draw <= 1'b1;
			else if (start_x)
				draw <= 1'b0;
		end
	end

	// last value seen while enter is held wins
	always_ff @(posedge clock) begin
		if (state == poly_ctrl_pkg::st_get_x && enter)
			xs[point_idx] <= data_ext;
		if (state == poly_ctrl_pkg::st_get_y && enter)
			ys[point_idx] <= data_ext;
		if (state == poly_ctrl_pkg::st_get_y && !enter) begin
			x_val <= xs[point_idx][poly_num_pkg::x_coord_width-1:0];
			y_val <= ys[point_idx][poly_num_pkg::y_coord_width-1:0];
		end
	end

	assign clear = (state == poly_ctrl_pkg::st_show_point) && last_point;
	assign step = (state == poly_ctrl_pkg::st_step);
	assign finished = (state == poly_ctrl_pkg::st_done);

endmodule

// File: rtl/poly_trainer_top.sv
module poly_trainer_top (
	input  logic                                      clock,
	input  logic                                      reset,
	input  logic                                      enter,
	input  logic signed [poly_num_pkg::entry_width-1:0] data_in,
	input  logic                                      plot_done,
	output poly_num_pkg::coef_vec_t                   params,
	output logic [poly_num_pkg::x_coord_width-1:0]    x_val,
	output logic [poly_num_pkg::y_coord_width-1:0]    y_val,
	output logic                                      draw,
	output logic                                      training_done,
	output logic                                      finished
);

	// sample points held for the whole run
	poly_num_pkg::point_vec_t xs;
	poly_num_pkg::point_vec_t ys;

	logic clear;
	logic step;
	logic step_done;

	poly_control u_control (
		.clock     (clock),
		.reset     (reset),
		.enter     (enter),
		.data_in   (data_in),
		.plot_done (plot_done),
		.step_done (step_done),
		.xs        (xs),
		.ys        (ys),
		.x_val     (x_val),
		.y_val     (y_val),
		.draw      (draw),
		.clear     (clear),
		.step      (step),
		.finished  (finished)
	);

	gradient_step u_step (
		.clock     (clock),
		.reset     (reset),
		.clear     (clear),
		.step      (step),
		.xs        (xs),
		.ys        (ys),
		.params    (params),
		.step_done (step_done)
	);

	// one pulse per finished iteration, params already updated
	assign training_done = step_done;

endmodule

// File: verif/poly_trainer_asserts.sv
module poly_trainer_asserts (
	input logic clock,
	input logic reset,
	input logic step,
	input logic step_done,
	input logic clear,
	input logic finished,
	input logic training_done
);
	timeunit 1ns;
	timeprecision 100ps;

	// three registers deep through hypotheses, gradients and coefficients
	step_to_done: assert property (@(posedge clock) disable iff (reset)
		$past(step, 3) |-> step_done)
		else $error("step_done missing three cycles after step");

	done_from_step: assert property (@(posedge clock) disable iff (reset)
		step_done |-> $past(step, 3))
		else $error("step_done without a step three cycles earlier");

	done_one_cycle: assert property (@(posedge clock) disable iff (reset)
		training_done |=> !training_done)
		else $error("training_done held longer than one cycle");

	// the done state is left only by a new entry
	no_step_when_finished: assert property (@(posedge clock) disable iff (reset)
		finished |=> !step)
		else $error("step issued right after finished");

	// clear zeroes params so no step may still be in the pipeline
	no_clear_with_step: assert property (@(posedge clock) disable iff (reset)
		clear |-> !step && !$past(step) && !$past(step, 2))
		else $error("clear while a step is still in the pipeline");

endmodule

// File: verif/tb_poly_trainer.sv
module tb_poly_trainer;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clock_period = 40;
	localparam int drive_delay = 2;
	localparam int reset_cycles = 3;
	localparam int seed = 22;
	localparam int num_runs = 3;
	localparam int num_rows = num_runs * poly_num_pkg::num_points;
	localparam int idle_check_cycles = 20;

	// step, pipeline, plotter wait of up to 8 and the state hops around it
	localparam int iter_worst_cycles = 16;
	// press of up to 5 cycles plus 2 released
	localparam int entry_worst_cycles = 7;
	localparam int timeout_cycles = 2 * num_runs * (poly_ctrl_pkg::num_iterations *
		iter_worst_cycles + 2 * poly_num_pkg::num_points * entry_worst_cycles + 10);

	localparam int max_value = 2 ** (poly_num_pkg::data_width - 1) - 1;
	localparam int min_value = -(2 ** (poly_num_pkg::data_width - 1));

	localparam int col_x = 0;
	localparam int col_y = 1;
	localparam int col_x_val = 2;
	localparam int col_y_val = 3;

	// entered x, entered y, expected x_val, expected y_val; four rows per run
	localparam int point_table [num_rows][4] = '{
		'{  0,   1, 'h000, 'h01},
		'{  1,   2, 'h001, 'h02},
		'{  2,   3, 'h002, 'h03},
		'{  3,   5, 'h003, 'h05},
		'{ -3,   5, 'h1fd, 'h05},
		'{ -1,  -2, 'h1ff, 'hfe},
		'{  2,  -4, 'h002, 'hfc},
		'{  4,   7, 'h004, 'h07},
		'{ 15,  15, 'h00f, 'h0f},
		'{-16, -16, 'h1f0, 'hf0},
		'{ 14, -15, 'h00e, 'hf1},
		'{-13,  12, 'h1f3, 'h0c}
	};

	typedef logic signed [poly_num_pkg::entry_width-1:0] entry_t;

	logic clock;
	logic reset;
	logic enter;
	entry_t data_in;
	logic plot_done;
	poly_num_pkg::coef_vec_t params;
	logic [poly_num_pkg::x_coord_width-1:0] x_val;
	logic [poly_num_pkg::y_coord_width-1:0] y_val;
	logic draw;
	logic training_done;
	logic finished;

	int cycle_count;
	int ref_run;
	int ref_iter;
	int runs_done;
	int exp_coef [poly_num_pkg::num_coefs];
	int ovf_per_run [num_runs];

	poly_trainer_top UUT (
		.clock         (clock),
		.reset         (reset),
		.enter         (enter),
		.data_in       (data_in),
		.plot_done     (plot_done),
		.params        (params),
		.x_val         (x_val),
		.y_val         (y_val),
		.draw          (draw),
		.training_done (training_done),
		.finished      (finished)
	);

	bind poly_trainer_top poly_trainer_asserts u_asserts (
		.clock         (clock),
		.reset         (reset),
		.step          (step),
		.step_done     (step_done),
		.clear         (clear),
		.finished      (finished),
		.training_done (training_done)
	);

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual !== expected) begin
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	// keep the low data_width bits as a signed value
	function automatic int wrap(input int v);
		poly_num_pkg::value_t t;
		t = poly_num_pkg::value_t'(v);
		return int'(t);
	endfunction

	function automatic bit add_overflows(input int a, input int b);
		int s;
		s = a + b;
		return (s > max_value) || (s < min_value);
	endfunction

	// cubic for one point, zero if any partial sum leaves the signed range
	function automatic int cubic_value(input int x, input int c [poly_num_pkg::num_coefs],
		output bit ovf);
		int x2, x3, t1, t2, t3, s1, s2, s3;
		x2 = wrap(x * x);
		x3 = wrap(x * x2);
		t1 = wrap(c[1] * x);
		t2 = wrap(c[2] * x2);
		t3 = wrap(c[3] * x3);
		ovf = add_overflows(c[0], t1);
		s1 = wrap(c[0] + t1);
		ovf = ovf || add_overflows(s1, t2);
		s2 = wrap(s1 + t2);
		ovf = ovf || add_overflows(s2, t3);
		s3 = wrap(s2 + t3);
		return ovf ? 0 : s3;
	endfunction

	// one gradient-descent iteration, returns how many hypotheses overflowed
	function automatic int descend(input int run, inout int c [poly_num_pkg::num_coefs]);
		int g [poly_num_pkg::num_coefs];
		int x, y, x2, x3, h, e;
		int ovf_points;
		bit ovf;
		g = '{default: 0};
		ovf_points = 0;
		for (int p = 0; p < poly_num_pkg::num_points; p++) begin
			x = point_table[run * poly_num_pkg::num_points + p][col_x];
			y = point_table[run * poly_num_pkg::num_points + p][col_y];
			h = cubic_value(x, c, ovf);
			if (ovf)
				ovf_points++;
			e = wrap(h - y);
			x2 = wrap(x * x);
			x3 = wrap(x * x2);
			g[0] = wrap(g[0] + e);
			g[1] = wrap(g[1] + wrap(x * e));
			g[2] = wrap(g[2] + wrap(x2 * e));
			g[3] = wrap(g[3] + wrap(x3 * e));
		end
		for (int k = 0; k < poly_num_pkg::num_coefs; k++)
			c[k] = wrap(c[k] - (g[k] >>> poly_num_pkg::grad_shift));
		return ovf_points;
	endfunction

	// hold one value on data_in with enter high, then release
	task automatic enter_value(input int value, input bit is_x);
		int hold;
		hold = $urandom_range(5, 2);
		enter = 1'b1;
		data_in = entry_t'(value);
		@(posedge clock);
		#drive_delay;
		if (is_x)
			check_value("draw", int'(draw), 0);
		repeat (hold - 1) begin
			@(posedge clock);
			#drive_delay;
		end
		enter = 1'b0;
		repeat (2) begin
			@(posedge clock);
			#drive_delay;
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clock);
			cycle_count++;
			if (cycle_count >= timeout_cycles)
				stop_run("timeout: training did not finish within the cycle limit");
		end
	end

	// plotter answers each training_done after 1 to 8 cycles
	initial begin
		int wait_cycles;
		plot_done = 1'b0;
		forever begin
			@(negedge clock);
			if (training_done) begin
				wait_cycles = $urandom_range(8, 1);
				repeat (wait_cycles) @(posedge clock);
				#drive_delay plot_done = 1'b1;
				@(posedge clock);
				#drive_delay plot_done = 1'b0;
			end
		end
	end

	// reference coefficients follow every training_done pulse
	initial begin
		ref_run = 0;
		ref_iter = 0;
		runs_done = 0;
		exp_coef = '{default: 0};
		ovf_per_run = '{default: 0};
		forever begin
			@(negedge clock);
			if (training_done) begin
				ovf_per_run[ref_run] += descend(ref_run, exp_coef);
				ref_iter++;
				for (int k = 0; k < poly_num_pkg::num_coefs; k++)
					check_value($sformatf("params[%0d]", k), int'(params[k]), exp_coef[k]);
				if (ref_iter == poly_ctrl_pkg::num_iterations) begin
					runs_done++;
					ref_run++;
					ref_iter = 0;
					exp_coef = '{default: 0};
				end
			end
		end
	end

	initial begin
		int row;
		void'($urandom(seed));
		reset = 1'b1;
		enter = 1'b0;
		data_in = '0;
		repeat (reset_cycles) @(posedge clock);
		#drive_delay reset = 1'b0;

		check_value("draw", int'(draw), 0);
		check_value("training_done", int'(training_done), 0);
		check_value("finished", int'(finished), 0);
		for (int k = 0; k < poly_num_pkg::num_coefs; k++)
			check_value($sformatf("params[%0d]", k), int'(params[k]), 0);

		for (int run = 0; run < num_runs; run++) begin
			for (int p = 0; p < poly_num_pkg::num_points; p++) begin
				row = run * poly_num_pkg::num_points + p;
				enter_value(point_table[row][col_x], 1'b1);
				enter_value(point_table[row][col_y], 1'b0);
				check_value("draw", int'(draw), 1);
				check_value("x_val", int'(x_val), point_table[row][col_x_val]);
				check_value("y_val", int'(y_val), point_table[row][col_y_val]);
			end
			while (!finished) begin
				@(posedge clock);
				#drive_delay;
			end
			check_value("completed runs", runs_done, run + 1);
			// plotter has answered, training must stay idle now
			repeat (idle_check_cycles) begin
				@(posedge clock);
				#drive_delay;
				check_value("training_done", int'(training_done), 0);
				check_value("finished", int'(finished), 1);
			end
		end

		if (ovf_per_run[num_runs - 1] == 0) begin
			stop_run("last run never drove a hypothesis into overflow");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

// File: tb.f
rtl/poly_num_pkg.sv
rtl/poly_ctrl_pkg.sv
rtl/hypothesis_eval.sv
rtl/gradient_step.sv
rtl/poly_control.sv
rtl/poly_trainer_top.sv
verif/poly_trainer_asserts.sv
verif/tb_poly_trainer.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_poly_trainer
FILELIST  := tb.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir
